/* gfx_mem.f */
hw/gfx_mem_pkg.sv
hw/gfx_wbm_read.sv
hw/gfx_wbm_write.sv
hw/gfx_wb_arbiter.sv
hw/gfx_mem_port.sv
testbench/wb_mem_model.sv
testbench/gfx_mem_tb.sv

/* hw/gfx_mem_pkg.sv */
// ==============================
// shared widths, data types and
// FSM state encodings of the
// graphics memory port
// ==============================
package gfx_mem_pkg;

	// ============================
	// widths
	// ============================
	localparam int ADR_W    = 32;	// byte address
	localparam int LINE_W   = 128;	// one memory line
	localparam int LINE_OFS = 4;	// byte offset bits inside a line
	localparam int CLIENT_W = 2;	// read client index

	typedef logic [ADR_W-1:0]    gfx_adr_t;
	typedef logic [LINE_W-1:0]   gfx_line_t;
	typedef logic [CLIENT_W-1:0] gfx_client_t;

	// read client numbers, m2 has highest priority
	localparam gfx_client_t CLIENT_M0 = 2'd0;
	localparam gfx_client_t CLIENT_M1 = 2'd1;
	localparam gfx_client_t CLIENT_M2 = 2'd2;

	// ============================
	// FSM states
	// ============================
	typedef enum logic [2:0] {
		RD_IDLE,
		RD_TEST_MATCH,	// writer compare on latched address
		RD_MATCH,	// answer from write buffer
		RD_ACK,		// bus read in flight
		RD_NACK		// ack held, wait for client
	} rd_state_t;

	typedef enum logic {
		WR_IDLE,
		WR_FLUSH	// line valid, bus write pending
	} wr_state_t;

endpackage

/* hw/gfx_mem_port.sv */
// ==============================
// memory port top: reader,
// write buffer and bus arbiter
// ==============================
`timescale 1ns/100ps

module gfx_mem_port (
	input  logic                  clk_i,
	input  logic                  rst_i,
	// external wishbone
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	output logic                  wb_we_o,
	output gfx_mem_pkg::gfx_adr_t  wb_adr_o,
	output gfx_mem_pkg::gfx_line_t wb_dat_o,
	input  logic                  wb_ack_i,
	input  logic                  wb_err_i,
	input  gfx_mem_pkg::gfx_line_t wb_dat_i,
	// read clients
	input  logic                  m0_read_request_i,
	input  gfx_mem_pkg::gfx_adr_t  m0_adr_i,
	output logic                  m0_ack_o,
	input  logic                  m0_nack_i,
	output gfx_mem_pkg::gfx_line_t m0_dat_o,
	input  logic                  m1_read_request_i,
	input  gfx_mem_pkg::gfx_adr_t  m1_adr_i,
	output logic                  m1_ack_o,
	input  logic                  m1_nack_i,
	output gfx_mem_pkg::gfx_line_t m1_dat_o,
	input  logic                  m2_read_request_i,
	input  gfx_mem_pkg::gfx_adr_t  m2_adr_i,
	output logic                  m2_ack_o,
	input  logic                  m2_nack_i,
	output gfx_mem_pkg::gfx_line_t m2_dat_o,
	// write client
	input  logic                  wr_req_i,
	input  gfx_mem_pkg::gfx_adr_t  wr_adr_i,
	input  gfx_mem_pkg::gfx_line_t wr_dat_i,
	output logic                  wr_busy_o
);
	import gfx_mem_pkg::*;

	// reader <-> arbiter
	logic      rd_cyc;
	gfx_adr_t  rd_adr;	// also drives the writer compare
	logic      rd_ack;
	logic      rd_err;
	// writer <-> arbiter
	logic      wr_cyc;
	gfx_adr_t  wr_bus_adr;
	gfx_line_t wr_bus_dat;
	logic      wr_ack;
	logic      wr_err;
	// writer -> reader bypass
	logic      wr_match;
	gfx_line_t wr_line;

	gfx_wbm_read u_read (
		.clk_i             (clk_i),
		.rst_i             (rst_i),
		.cyc_o             (rd_cyc),
		.adr_o             (rd_adr),
		.ack_i             (rd_ack),
		.err_i             (rd_err),
		.dat_i             (wb_dat_i),	// bus data straight in
		.m0_read_request_i (m0_read_request_i),
		.m0_adr_i          (m0_adr_i),
		.m0_ack_o          (m0_ack_o),
		.m0_nack_i         (m0_nack_i),
		.m0_dat_o          (m0_dat_o),
		.m1_read_request_i (m1_read_request_i),
		.m1_adr_i          (m1_adr_i),
		.m1_ack_o          (m1_ack_o),
		.m1_nack_i         (m1_nack_i),
		.m1_dat_o          (m1_dat_o),
		.m2_read_request_i (m2_read_request_i),
		.m2_adr_i          (m2_adr_i),
		.m2_ack_o          (m2_ack_o),
		.m2_nack_i         (m2_nack_i),
		.m2_dat_o          (m2_dat_o),
		.writer_match_i    (wr_match),
		.writer_dat_i      (wr_line)
	);

	gfx_wbm_write u_write (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.wr_req_i  (wr_req_i),
		.wr_adr_i  (wr_adr_i),
		.wr_dat_i  (wr_dat_i),
		.wr_busy_o (wr_busy_o),
		.rd_adr_i  (rd_adr),
		.match_o   (wr_match),
		.line_o    (wr_line),
		.cyc_o     (wr_cyc),
		.adr_o     (wr_bus_adr),
		.dat_o     (wr_bus_dat),
		.ack_i     (wr_ack),
		.err_i     (wr_err)
	);

	gfx_wb_arbiter u_arb (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.rd_cyc_i (rd_cyc),
		.rd_adr_i (rd_adr),
		.rd_ack_o (rd_ack),
		.rd_err_o (rd_err),
		.wr_cyc_i (wr_cyc),
		.wr_adr_i (wr_bus_adr),
		.wr_dat_i (wr_bus_dat),
		.wr_ack_o (wr_ack),
		.wr_err_o (wr_err),
		.wb_cyc_o (wb_cyc_o),
		.wb_stb_o (wb_stb_o),
		.wb_we_o  (wb_we_o),
		.wb_adr_o (wb_adr_o),
		.wb_dat_o (wb_dat_o),
		.wb_ack_i (wb_ack_i),
		.wb_err_i (wb_err_i)
	);

endmodule

/* hw/gfx_wb_arbiter.sv */
// ==============================
// two-master Wishbone arbiter,
// write wins ties, port locked
// for a whole cycle
// ==============================
`timescale 1ns/100ps

module gfx_wb_arbiter (
	input  logic                  clk_i,
	input  logic                  rst_i,
	// read master
	input  logic                  rd_cyc_i,
	input  gfx_mem_pkg::gfx_adr_t  rd_adr_i,
	output logic                  rd_ack_o,
	output logic                  rd_err_o,
	// write master
	input  logic                  wr_cyc_i,
	input  gfx_mem_pkg::gfx_adr_t  wr_adr_i,
	input  gfx_mem_pkg::gfx_line_t wr_dat_i,
	output logic                  wr_ack_o,
	output logic                  wr_err_o,
	// shared port
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	output logic                  wb_we_o,
	output gfx_mem_pkg::gfx_adr_t  wb_adr_o,
	output gfx_mem_pkg::gfx_line_t wb_dat_o,
	input  logic                  wb_ack_i,
	input  logic                  wb_err_i
);
	logic locked_q;		// a cycle is in progress
	logic owner_wr_q;	// 1 = writer owns the port
	logic grant_wr;		// effective grant this cycle
	logic bus_done;

	assign bus_done = wb_ack_i | wb_err_i;

	// free port: grant in the same cycle, write first
	assign grant_wr = locked_q ? owner_wr_q : wr_cyc_i;

	// ==============================
	// owner lock
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			locked_q   <= 1'b0;
			owner_wr_q <= 1'b0;
		end else if (locked_q) begin
			if (bus_done)
				locked_q <= 1'b0;	// owner drops cyc on this edge too
		end else if (wb_cyc_o && !bus_done) begin
			locked_q   <= 1'b1;
			owner_wr_q <= wr_cyc_i;
		end
	end

	// ==============================
	// port mux
	// ==============================
	assign wb_cyc_o = grant_wr ? wr_cyc_i : rd_cyc_i;
	assign wb_stb_o = wb_cyc_o;			// single cycles only
	assign wb_we_o  = wb_cyc_o & grant_wr;
	assign wb_adr_o = grant_wr ? wr_adr_i : rd_adr_i;
	assign wb_dat_o = grant_wr ? wr_dat_i : '0;

	// returns only reach the granted master
	assign rd_ack_o = wb_ack_i & wb_cyc_o & ~grant_wr;
	assign rd_err_o = wb_err_i & wb_cyc_o & ~grant_wr;
	assign wr_ack_o = wb_ack_i & wb_cyc_o & grant_wr;
	assign wr_err_o = wb_err_i & wb_cyc_o & grant_wr;

endmodule

/* hw/gfx_wbm_read.sv */
// ==============================
// three-client Wishbone read
// master, fixed priority, with
// write buffer bypass
// ==============================
`timescale 1ns/100ps

module gfx_wbm_read (
	input  logic                  clk_i,
	input  logic                  rst_i,
	// wishbone side
	output logic                  cyc_o,
	output gfx_mem_pkg::gfx_adr_t  adr_o,		// latched client address
	input  logic                  ack_i,
	input  logic                  err_i,
	input  gfx_mem_pkg::gfx_line_t dat_i,
	// client 0, lowest priority
	input  logic                  m0_read_request_i,
	input  gfx_mem_pkg::gfx_adr_t  m0_adr_i,
	output logic                  m0_ack_o,
	input  logic                  m0_nack_i,
	output gfx_mem_pkg::gfx_line_t m0_dat_o,
	// client 1
	input  logic                  m1_read_request_i,
	input  gfx_mem_pkg::gfx_adr_t  m1_adr_i,
	output logic                  m1_ack_o,
	input  logic                  m1_nack_i,
	output gfx_mem_pkg::gfx_line_t m1_dat_o,
	// client 2, highest priority
	input  logic                  m2_read_request_i,
	input  gfx_mem_pkg::gfx_adr_t  m2_adr_i,
	output logic                  m2_ack_o,
	input  logic                  m2_nack_i,
	output gfx_mem_pkg::gfx_line_t m2_dat_o,
	// write buffer
	input  logic                  writer_match_i,
	input  gfx_mem_pkg::gfx_line_t writer_dat_i
);
	import gfx_mem_pkg::*;

	rd_state_t   state;
	gfx_client_t master_sel;	// client being served

	// ==============================
	// control FSM
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cyc_o      <= 1'b0;
			adr_o      <= '0;
			m0_ack_o   <= 1'b0;
			m1_ack_o   <= 1'b0;
			m2_ack_o   <= 1'b0;
			master_sel <= CLIENT_M0;
			state      <= RD_IDLE;
		end else begin
			case (state)
			RD_IDLE: begin
				// priority pick, m2 first
				if (m2_read_request_i) begin
					master_sel <= CLIENT_M2;
					adr_o      <= m2_adr_i;
					state      <= RD_TEST_MATCH;
				end else if (m1_read_request_i) begin
					master_sel <= CLIENT_M1;
					adr_o      <= m1_adr_i;
					state      <= RD_TEST_MATCH;
				end else if (m0_read_request_i) begin
					master_sel <= CLIENT_M0;
					adr_o      <= m0_adr_i;
					state      <= RD_TEST_MATCH;
				end
			end
			RD_TEST_MATCH: begin
				// writer compares against adr_o this cycle
				if (writer_match_i)
					state <= RD_MATCH;
				else begin
					cyc_o <= 1'b1;	// go to memory
					state <= RD_ACK;
				end
			end
			RD_MATCH: begin
				case (master_sel)
				CLIENT_M0: m0_ack_o <= 1'b1;
				CLIENT_M1: m1_ack_o <= 1'b1;
				default:   m2_ack_o <= 1'b1;
				endcase
				state <= RD_NACK;
			end
			RD_ACK: begin
				// err finishes the read just like ack
				if (ack_i | err_i) begin
					cyc_o <= 1'b0;
					case (master_sel)
					CLIENT_M0: m0_ack_o <= 1'b1;
					CLIENT_M1: m1_ack_o <= 1'b1;
					default:   m2_ack_o <= 1'b1;
					endcase
					state <= RD_NACK;
				end
			end
			RD_NACK: begin
				// any nack releases the held ack
				if (m0_nack_i | m1_nack_i | m2_nack_i) begin
					m0_ack_o <= 1'b0;
					m1_ack_o <= 1'b0;
					m2_ack_o <= 1'b0;
					state    <= RD_IDLE;
				end
			end
			default: begin
				cyc_o <= 1'b0;
				state <= RD_IDLE;
			end
			endcase
		end
	end

	// ==============================
	// client data registers
	// ==============================
	// loaded with the ack, held until the next answer to that client
	always_ff @(posedge clk_i) begin
		if (state == RD_MATCH) begin
			case (master_sel)
			CLIENT_M0: m0_dat_o <= writer_dat_i;
			CLIENT_M1: m1_dat_o <= writer_dat_i;
			default:   m2_dat_o <= writer_dat_i;
			endcase
		end else if (state == RD_ACK && (ack_i | err_i)) begin
			case (master_sel)
			CLIENT_M0: m0_dat_o <= dat_i;
			CLIENT_M1: m1_dat_o <= dat_i;
			default:   m2_dat_o <= dat_i;
			endcase
		end
	end

endmodule

/* hw/gfx_wbm_write.sv */
// ==============================
// one-line write buffer, flushes
// to Wishbone and reports
// address hits to the reader
// ==============================
`timescale 1ns/100ps

module gfx_wbm_write (
	input  logic                  clk_i,
	input  logic                  rst_i,
	// write client
	input  logic                  wr_req_i,	// one-cycle pulse
	input  gfx_mem_pkg::gfx_adr_t  wr_adr_i,
	input  gfx_mem_pkg::gfx_line_t wr_dat_i,
	output logic                  wr_busy_o,
	// reader bypass
	input  gfx_mem_pkg::gfx_adr_t  rd_adr_i,	// reader's latched address
	output logic                  match_o,
	output gfx_mem_pkg::gfx_line_t line_o,
	// wishbone side
	output logic                  cyc_o,
	output gfx_mem_pkg::gfx_adr_t  adr_o,
	output gfx_mem_pkg::gfx_line_t dat_o,
	input  logic                  ack_i,
	input  logic                  err_i
);
	import gfx_mem_pkg::*;

	wr_state_t state;
	gfx_adr_t  held_adr;	// line aligned
	gfx_line_t held_line;
	logic      line_valid;
	logic      accept;	// request taken this cycle
	logic      bus_done;	// slave ended the write

	assign accept   = (state == WR_IDLE) && wr_req_i;
	assign bus_done = ack_i | err_i;

	// ==============================
	// flush FSM
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= WR_IDLE;
		end else begin
			case (state)
			WR_IDLE: begin
				if (accept)
					state <= WR_FLUSH;	// pulse while busy never gets here
			end
			WR_FLUSH: begin
				if (bus_done)
					state <= WR_IDLE;	// line invalid from next cycle
			end
			default: state <= WR_IDLE;
			endcase
		end
	end

	// payload, no reset needed
	always_ff @(posedge clk_i) begin
		if (accept) begin
			held_adr  <= {wr_adr_i[ADR_W-1:LINE_OFS], {LINE_OFS{1'b0}}};
			held_line <= wr_dat_i;
		end
	end

	// line is valid exactly while it waits for the bus
	assign line_valid = (state == WR_FLUSH);

	assign wr_busy_o = line_valid;
	assign cyc_o     = line_valid;	// held until ack or err
	assign adr_o     = held_adr;
	assign dat_o     = held_line;

	// ==============================
	// reader bypass
	// ==============================
	// compare on line index only, byte offset ignored
	assign match_o = line_valid &&
		(rd_adr_i[ADR_W-1:LINE_OFS] == held_adr[ADR_W-1:LINE_OFS]);
	assign line_o  = held_line;

endmodule

/* testbench/gfx_mem_tb.sv */
// ==============================
// memory port testbench with
// read and write clients, memory
// model, checks and watchdog
// ==============================
`timescale 1ns/100ps

module gfx_mem_tb;
	import gfx_mem_pkg::*;

	localparam int          CLK_PERIOD   = 40;
	localparam int          RST_CYCLES   = 8;
	localparam int          N_TESTS      = 6;
	localparam int          CYC_PER_TEST = 200;	// watchdog budget
	localparam int          WAIT_LIMIT   = 50;	// per handshake
	localparam logic [31:0] ERR_BASE     = 32'hF000_0000;
	localparam int          MEM_SEED     = 32'h3500;

	logic      clk = 1'b0;
	logic      rst;
	// wishbone
	logic      wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
	gfx_adr_t  wb_adr;
	gfx_line_t wb_dat_w;	// to memory
	gfx_line_t wb_dat_r;	// from memory
	// read clients indexed by client number
	logic [2:0] req, nack, ack;
	gfx_adr_t   adr [3];
	gfx_line_t  dat [3];
	// write client
	logic      wr_req, wr_busy;
	gfx_adr_t  wr_adr;
	gfx_line_t wr_dat;
	// expectations
	logic [2:0] pend;		// request out and no nack yet
	logic [2:0] chk_dat;		// compare data on the ack
	gfx_line_t  exp_dat [3];
	string      test_name;
	int         errors, errs_before, tests_run, n;

	always #(CLK_PERIOD / 2) clk = ~clk;

	gfx_mem_port UUT (
		.clk_i (clk), .rst_i (rst),
		.wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_we_o (wb_we),
		.wb_adr_o (wb_adr), .wb_dat_o (wb_dat_w),
		.wb_ack_i (wb_ack), .wb_err_i (wb_err), .wb_dat_i (wb_dat_r),
		.m0_read_request_i (req[0]), .m0_adr_i (adr[0]), .m0_ack_o (ack[0]),
		.m0_nack_i (nack[0]), .m0_dat_o (dat[0]),
		.m1_read_request_i (req[1]), .m1_adr_i (adr[1]), .m1_ack_o (ack[1]),
		.m1_nack_i (nack[1]), .m1_dat_o (dat[1]),
		.m2_read_request_i (req[2]), .m2_adr_i (adr[2]), .m2_ack_o (ack[2]),
		.m2_nack_i (nack[2]), .m2_dat_o (dat[2]),
		.wr_req_i (wr_req), .wr_adr_i (wr_adr), .wr_dat_i (wr_dat), .wr_busy_o (wr_busy)
	);

	wb_mem_model #(.ERR_BASE (ERR_BASE), .SEED (MEM_SEED)) u_mem (
		.clk_i (clk), .rst_i (rst), .cyc_i (wb_cyc), .stb_i (wb_stb), .we_i (wb_we),
		.adr_i (wb_adr), .dat_i (wb_dat_w),
		.ack_o (wb_ack), .err_o (wb_err), .dat_o (wb_dat_r)
	);

	// print a failed check and count it
	task automatic report_error(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	// ==============================
	// checks
	// ==============================
	assert property (@(posedge clk) rst |=> (!wb_cyc && ack == 3'b000 && !wr_busy))
	else report_error($sformatf("%s: outputs not idle after reset", test_name));

	assert property (@(posedge clk) disable iff (rst) $onehot0(ack))
	else report_error($sformatf("%s: more than one client ack high", test_name));

	assert property (@(posedge clk) disable iff (rst) (|ack) && (|nack) |=> ack == 3'b000)
	else report_error($sformatf("%s: ack not released after nack", test_name));

	assert property (@(posedge clk) disable iff (rst) wb_stb == wb_cyc)
	else report_error($sformatf("%s: stb differs from cyc", test_name));

	// a write goes to the line the client handed over
	assert property (@(posedge clk) disable iff (rst) wb_cyc && wb_we |-> wb_adr == wr_adr)
	else report_error($sformatf("FAILED %s write address: expected %h, actual %h",
		test_name, wr_adr, $sampled(wb_adr)));

	assert property (@(posedge clk) disable iff (rst) wb_cyc && wb_we |-> wb_dat_w == wr_dat)
	else report_error($sformatf("FAILED %s write data: expected %h, actual %h",
		test_name, wr_dat, $sampled(wb_dat_w)));

	// a finished bus read (ack or err) always reaches a client
	assert property (@(posedge clk) disable iff (rst)
		wb_cyc && !wb_we && (wb_ack || wb_err) |=> (|ack))
	else report_error($sformatf("%s: bus read ended without client ack", test_name));

	for (genvar c = 0; c < 3; c++) begin : g_client
		assert property (@(posedge clk) disable iff (rst)
			$rose(ack[c]) |-> (!chk_dat[c] || dat[c] == exp_dat[c]))
		else report_error($sformatf("FAILED %s client %0d: expected %h, actual %h",
			test_name, c, exp_dat[c], dat[c]));

		assert property (@(posedge clk) disable iff (rst) $rose(ack[c]) |-> pend[c])
		else report_error($sformatf("%s: client %0d acked without request",
			test_name, c));

		// no higher priority client may still be waiting
		assert property (@(posedge clk) disable iff (rst)
			$rose(ack[c]) |-> (pend >> (c + 1)) == 3'b000)
		else report_error($sformatf("%s: client %0d served out of order",
			test_name, c));

		assert property (@(posedge clk) disable iff (rst) ack[c] && !(|nack) |=> ack[c])
		else report_error($sformatf("%s: client %0d ack dropped early", test_name, c));

		// bypass from the write buffer answers in 3 cycles
		assert property (@(posedge clk) disable iff (rst)
			($rose(req[c]) && wr_busy && adr[c][31:4] == wr_adr[31:4]) ##1 wr_busy
			|-> ##2 $rose(ack[c]))
		else report_error($sformatf("%s: client %0d bypass ack late", test_name, c));
	end

	// ==============================
	// stimulus tasks
	// ==============================
	function automatic gfx_line_t preload_line(input gfx_adr_t a);
		return {4{a[31:4], 4'h0}};
	endfunction

	task automatic start_read(input int c, input gfx_adr_t a, input gfx_line_t e,
		input logic chk);
		exp_dat[c] = e;
		chk_dat[c] = chk;
		adr[c]     = a;
		req[c]     = 1'b1;
		pend[c]    = 1'b1;
	endtask

	task automatic finish_read(input int c);
		int t;
		t = 0;
		while (!ack[c] && t < WAIT_LIMIT) begin
			@(negedge clk);
			t++;
		end
		if (!ack[c])
			report_error($sformatf("%s: client %0d got no ack", test_name, c));
		req[c] = 1'b0;	// request down before the nack
		@(negedge clk);
		nack[c] = 1'b1;
		pend[c] = 1'b0;
		@(negedge clk);
		nack[c] = 1'b0;
	endtask

	task automatic wait_write_done();
		int t;
		t = 0;
		while (wr_busy && t < WAIT_LIMIT) begin
			@(negedge clk);
			t++;
		end
		if (wr_busy)
			report_error($sformatf("%s: write buffer never flushed", test_name));
	endtask

	task automatic write_line(input gfx_adr_t a, input gfx_line_t d);
		wait_write_done();
		wr_adr = a;
		wr_dat = d;
		wr_req = 1'b1;	// one-cycle pulse
		@(negedge clk);
		wr_req = 1'b0;
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		errs_before = errors;
	endtask

	task automatic end_test();
		tests_run++;
		$display("test %0d %-28s %s", tests_run, test_name,
			(errors == errs_before) ? "ok" : "failed");
	endtask

	// ==============================
	// test sequence
	// ==============================
	initial begin
		rst = 1'b1;
		{wr_req, req, nack, pend, chk_dat} = '0;
		wr_adr = '0;
		wr_dat = '0;
		for (n = 0; n < 3; n++) begin
			adr[n]     = '0;
			exp_dat[n] = '0;
		end
		errors    = 0;
		tests_run = 0;
		begin_test("reset state");
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		repeat (2) @(negedge clk);
		end_test();

		begin_test("single reads");
		for (n = 0; n < 3; n++) begin
			start_read(n, 32'h0012_3400 + 32'h0100_0010 * n,
				preload_line(32'h0012_3400 + 32'h0100_0010 * n), 1'b1);
			finish_read(n);
		end
		end_test();

		begin_test("priority order");
		for (n = 0; n < 3; n++)
			start_read(n, 32'h100 * (n + 1), preload_line(32'h100 * (n + 1)), 1'b1);
		for (n = 2; n >= 0; n--)
			finish_read(n);
		end_test();

		begin_test("write then read same line");
		write_line(32'h0000_8000, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
		start_read(1, 32'h0000_8000, wr_dat, 1'b1);	// bypass path
		finish_read(1);
		wait_write_done();
		start_read(0, 32'h0000_8000, wr_dat, 1'b1);	// from memory
		finish_read(0);
		end_test();

		begin_test("read beside pending write");
		write_line(32'h0000_9000, 128'h5a5a_0000_1111_2222_3333_4444_5555_a5a5);
		start_read(2, 32'h0000_a000, preload_line(32'h0000_a000), 1'b1);
		finish_read(2);
		wait_write_done();
		start_read(0, 32'h0000_9000, wr_dat, 1'b1);
		finish_read(0);
		end_test();

		begin_test("error window read");
		start_read(0, ERR_BASE + 32'h40, '0, 1'b0);	// data undefined
		finish_read(0);
		start_read(0, 32'h0000_0050, preload_line(32'h0000_0050), 1'b1);
		finish_read(0);
		end_test();

		$display("tests run %0d, failed checks %0d", tests_run, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// watchdog
	initial begin
		#((RST_CYCLES + N_TESTS * CYC_PER_TEST) * CLK_PERIOD);
		$display("watchdog: run did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* testbench/wb_mem_model.sv */
// ==============================
// Wishbone slave memory model,
// random ack delay, error window
// ==============================
`timescale 1ns/100ps

module wb_mem_model #(
	parameter logic [31:0] ERR_BASE = 32'hF000_0000,	// err at and above
	parameter int          SEED     = 32'h3500
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   cyc_i,
	input  logic                   stb_i,
	input  logic                   we_i,
	input  gfx_mem_pkg::gfx_adr_t  adr_i,
	input  gfx_mem_pkg::gfx_line_t dat_i,
	output logic                   ack_o,
	output logic                   err_o,
	output gfx_mem_pkg::gfx_line_t dat_o
);
	import gfx_mem_pkg::*;

	localparam int SLOTS = 8;	// written lines kept

	gfx_adr_t  tag  [SLOTS];
	gfx_line_t line [SLOTS];
	logic      used [SLOTS];
	int        fill;		// next slot to replace
	integer    seed;
	int        delay;
	int        wait_cnt;
	logic      pending;		// delay already drawn for this cycle
	gfx_adr_t  line_adr;

	function automatic int find_slot(input gfx_adr_t a);
		int hit;
		hit = -1;
		for (int i = 0; i < SLOTS; i++)
			if (used[i] && tag[i] == a)
				hit = i;
		return hit;
	endfunction

	// unwritten lines read as their own address, four times over
	function automatic gfx_line_t fetch_line(input gfx_adr_t a);
		int s;
		s = find_slot(a);
		if (s >= 0)
			return line[s];
		return {4{a}};
	endfunction

	task automatic store_line(input gfx_adr_t a, input gfx_line_t d);
		int s;
		s = find_slot(a);
		if (s < 0) begin
			s = fill % SLOTS;
			fill = fill + 1;
		end
		used[s] = 1'b1;
		tag[s]  = a;
		line[s] = d;
	endtask

	initial begin
		seed    = SEED;
		fill    = 0;
		pending = 1'b0;
		ack_o   = 1'b0;
		err_o   = 1'b0;
		dat_o   = '0;
		for (int i = 0; i < SLOTS; i++)
			used[i] = 1'b0;
	end

	// ==============================
	// slave response
	// ==============================
	always @(posedge clk_i) begin
		ack_o <= 1'b0;	// single-cycle response
		err_o <= 1'b0;
		if (rst_i) begin
			pending <= 1'b0;
		end else if (cyc_i && stb_i && !ack_o && !err_o) begin
			if (pending)
				delay = wait_cnt;
			else
				delay = {$random(seed)} % 3;	// 0..2 extra waits
			if (delay != 0) begin
				pending  <= 1'b1;
				wait_cnt <= delay - 1;
			end else begin
				pending  <= 1'b0;
				line_adr = {adr_i[31:4], 4'h0};
				if (adr_i >= ERR_BASE) begin
					err_o <= 1'b1;	// error window
				end else if (we_i) begin
					store_line(line_adr, dat_i);
					ack_o <= 1'b1;
				end else begin
					dat_o <= fetch_line(line_adr);
					ack_o <= 1'b1;
				end
			end
		end
	end

endmodule
